// ==== tlk2711_tx.f ====
+incdir+include
hdl/tlk2711_tx_pkg.sv
hdl/tx_word_fifo.sv
hdl/frame_sequencer.sv
hdl/test_pattern_gen.sv
hdl/tlk2711_tx_top.sv
sim/tb_tlk2711_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tlk2711_tx.f \
    --top-module tb_tlk2711_tx -o sim_tlk2711_tx
./obj_dir/sim_tlk2711_tx | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    exit 0
else
    echo "simulation reported failure, see sim.log"
    exit 1
fi

// ==== sim/tb_tlk2711_tx.sv ====
//////////////////////////////////////////////////////////////////////
// directed testbench for the TLK2711 transmit framer
// inputs change on the falling edge and outputs are sampled there
// normal mode data is pushed right after start, long before DATA
//////////////////////////////////////////////////////////////////////
`include "tlk2711_tx_macros.svh"

module tb_tlk2711_tx;

    timeunit 1ns;
    timeprecision 100ps;

    // all six tests take about 2200 cycles, the rest is margin
    localparam int CYCLE_LIMIT = 40000;

    logic        clk;
    logic        i_soft_reset;
    logic [2:0]  i_tx_mode;
    logic        i_loopback_ena;
    logic        i_tx_pre;
    logic        i_tx_start;
    logic [15:0] i_tx_packet_body;
    logic [15:0] i_tx_packet_tail;
    logic [23:0] i_tx_body_num;
    logic        i_dma_rd_valid;
    logic [63:0] i_dma_rd_data;
    logic        o_dma_rd_ready;
    logic        o_tx_interrupt;
    logic [8:0]  o_tx_status;
    logic        o_2711_tkmsb;
    logic        o_2711_tklsb;
    logic        o_2711_enable;
    logic        o_2711_loopen;
    logic        o_2711_lckrefn;
    logic        o_2711_testen;
    logic        o_2711_prbsen;
    logic        o_2711_pre;
    logic [15:0] o_2711_txd;

    int          seed;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          irq_count = 0;
    // expected data half-words, in chip port order
    logic [15:0] exp_q[$];

    tlk2711_tx_top DUT (
        .clk              (clk),
        .i_soft_reset     (i_soft_reset),
        .i_tx_mode        (i_tx_mode),
        .i_loopback_ena   (i_loopback_ena),
        .i_tx_pre         (i_tx_pre),
        .i_tx_start       (i_tx_start),
        .i_tx_packet_body (i_tx_packet_body),
        .i_tx_packet_tail (i_tx_packet_tail),
        .i_tx_body_num    (i_tx_body_num),
        .i_dma_rd_valid   (i_dma_rd_valid),
        .i_dma_rd_data    (i_dma_rd_data),
        .o_dma_rd_ready   (o_dma_rd_ready),
        .o_tx_interrupt   (o_tx_interrupt),
        .o_tx_status      (o_tx_status),
        .o_2711_tkmsb     (o_2711_tkmsb),
        .o_2711_tklsb     (o_2711_tklsb),
        .o_2711_enable    (o_2711_enable),
        .o_2711_loopen    (o_2711_loopen),
        .o_2711_lckrefn   (o_2711_lckrefn),
        .o_2711_testen    (o_2711_testen),
        .o_2711_prbsen    (o_2711_prbsen),
        .o_2711_pre       (o_2711_pre),
        .o_2711_txd       (o_2711_txd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog and interrupt pulse counter
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (o_tx_interrupt) begin
            irq_count <= irq_count + 1;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_word(input string what, input logic [15:0] act,
                              input logic [1:0] act_k, input logic [15:0] exp_w,
                              input logic [1:0] exp_k);
        checks++;
        if (act !== exp_w || act_k !== exp_k) begin
            errors++;
            $display("ERR %0t: %s is %h k %b, expected %h k %b",
                     $time, what, act, act_k, exp_w, exp_k);
        end
    endtask

    task automatic check_state(input string what, input tlk2711_tx_pkg::tx_state_e act,
                               input tlk2711_tx_pkg::tx_state_e exp_s);
        checks++;
        if (act !== exp_s) begin
            errors++;
            $display("ERR %0t: %s is %s, expected %s", $time, what, act.name(), exp_s.name());
        end
    endtask

    task automatic check_bit(input string what, input logic act, input logic exp_b);
        checks++;
        if (act !== exp_b) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, act, exp_b);
        end
    endtask

    function automatic tlk2711_tx_pkg::tx_state_e status_state();
        return tlk2711_tx_pkg::tx_state_e'(o_tx_status[6:3]);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // drive helpers
    //////////////////////////////////////////////////////////////////////
    task automatic apply_reset();
        @(negedge clk);
        i_soft_reset   = 1'b1;
        i_tx_start     = 1'b0;
        i_dma_rd_valid = 1'b0;
        repeat (3) @(negedge clk);
        i_soft_reset = 1'b0;
    endtask

    task automatic pulse_start(input tlk2711_tx_pkg::tx_mode_e mode);
        @(negedge clk);
        i_tx_mode  = mode;
        i_tx_start = 1'b1;
        @(negedge clk);
        i_tx_start = 1'b0;
    endtask

    // one DMA beat, held while ready is low
    task automatic dma_write(input logic [63:0] w);
        i_dma_rd_valid = 1'b1;
        i_dma_rd_data  = w;
        while (!o_dma_rd_ready) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic load_words(input int n);
        logic [31:0] hi;
        logic [31:0] lo;
        for (int i = 0; i < n; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            exp_q.push_back(lo[15:0]);
            exp_q.push_back(lo[31:16]);
            exp_q.push_back(hi[15:0]);
            exp_q.push_back(hi[31:16]);
            dma_write({hi, lo});
        end
        i_dma_rd_valid = 1'b0;
    endtask

    task automatic expect_word(input logic [15:0] exp_w, input logic [1:0] exp_k,
                               input string what);
        @(negedge clk);
        check_word(what, o_2711_txd, {o_2711_tkmsb, o_2711_tklsb}, exp_w, exp_k);
    endtask

    task automatic wait_for_word(input logic [15:0] exp_w, input logic [1:0] exp_k,
                                 input int max_cycles);
        bit found;
        found = 1'b0;
        for (int i = 0; i < max_cycles && !found; i++) begin
            @(negedge clk);
            found = (o_2711_txd === exp_w) && ({o_2711_tkmsb, o_2711_tklsb} === exp_k);
        end
        if (!found) begin
            errors++;
            $display("word %h never showed up on the chip port within %0d cycles",
                     exp_w, max_cycles);
        end
    endtask

    // SOF already seen, checks the rest of frame k up to its last gap word
    task automatic check_frame(input int k, input bit last, input logic [15:0] len);
        logic [15:0] csum;
        logic [15:0] w;
        csum = 16'h0000;
        expect_word(`TLK_HEAD0, 2'b00, "head word 0");
        expect_word(`TLK_HEAD1, 2'b00, "head word 1");
        w = {`TLK_TX_IND, last ? `TLK_FILE_END : 8'h00};
        expect_word(w, 2'b00, "file sign");
        csum += w;
        w = k[15:0];
        expect_word(w, 2'b00, "frame number");
        csum += w;
        expect_word(len, 2'b00, "length");
        csum += len;
        for (int i = 0; i < int'(len[15:1]); i++) begin
            w = exp_q.pop_front();
            expect_word(w, 2'b00, "data word");
            csum += w;
        end
        expect_word(csum, 2'b00, "checksum");
        expect_word(`TLK_EOF, 2'b11, "end of frame");
        repeat (`TLK_GAP_WORDS) expect_word(`TLK_COMMA, 2'b01, "gap comma");
    endtask

    task automatic run_frames(input int body_num, input int body_len, input int tail_len);
        int          irq_base;
        logic [15:0] len;
        apply_reset();
        exp_q.delete();
        i_tx_packet_body = 16'(body_len);
        i_tx_packet_tail = 16'(tail_len);
        i_tx_body_num    = 24'(body_num);
        irq_base         = irq_count;
        pulse_start(tlk2711_tx_pkg::NORM);
        load_words((body_num * body_len + tail_len + 7) / 8);
        wait_for_word(`TLK_SOF, 2'b11, 100);
        for (int k = 0; k <= body_num; k++) begin
            if (k > 0) begin
                expect_word(`TLK_SOF, 2'b11, "start of frame");
            end
            len = (k == body_num) ? 16'(tail_len) : 16'(body_len);
            check_frame(k, k == body_num, len);
            if (k < body_num) begin
                check_bit("interrupt before last frame", irq_count != irq_base, 1'b0);
            end
        end
        expect_word(16'h0000, 2'b00, "idle word after run");
        repeat (2) @(negedge clk);
        check_bit("one interrupt per run", (irq_count - irq_base) == 1, 1'b1);
        check_state("state after run", status_state(), tlk2711_tx_pkg::IDLE);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_after_reset();
        apply_reset();
        @(negedge clk);
        check_bit("interrupt after reset", o_tx_interrupt, 1'b0);
        check_bit("dma ready after reset", o_dma_rd_ready, 1'b1);
        check_word("txd after reset", o_2711_txd, {o_2711_tkmsb, o_2711_tklsb}, 16'h0, 2'b00);
        check_state("state after reset", status_state(), tlk2711_tx_pkg::IDLE);
        check_bit("status fifo empty after reset", o_tx_status[8], 1'b1);
        check_bit("status fifo full after reset", o_tx_status[7], 1'b0);
        check_bit("enable", o_2711_enable, 1'b1);
        check_bit("lckrefn", o_2711_lckrefn, 1'b1);
        check_bit("testen", o_2711_testen, 1'b0);
        check_bit("prbsen", o_2711_prbsen, 1'b0);
        check_bit("loopen with input high", o_2711_loopen, 1'b1);
        check_bit("pre with input low", o_2711_pre, 1'b0);
        // flip both pass-through inputs
        i_loopback_ena = 1'b0;
        i_tx_pre       = 1'b1;
        @(negedge clk);
        check_bit("loopen with input low", o_2711_loopen, 1'b0);
        check_bit("pre with input high", o_2711_pre, 1'b1);
    endtask

    task automatic test_kcode();
        apply_reset();
        pulse_start(tlk2711_tx_pkg::KCODE);
        wait_for_word(`TLK_SOF, 2'b11, 10);
        check_bit("status mode is K-code",
                  tlk2711_tx_pkg::tx_mode_e'(o_tx_status[2:0]) == tlk2711_tx_pkg::KCODE,
                  1'b1);
        repeat (50) expect_word(`TLK_SOF, 2'b11, "K-code word");
    endtask

    task automatic test_pattern();
        logic [7:0] n8;
        apply_reset();
        pulse_start(tlk2711_tx_pkg::TEST);
        // the first comma found is the first of the pair
        wait_for_word(`TLK_COMMA, 2'b01, 10);
        for (int pass = 0; pass < 2; pass++) begin
            if (pass > 0) begin
                expect_word(`TLK_COMMA, 2'b01, "test comma 1");
            end
            expect_word(`TLK_COMMA, 2'b01, "test comma 2");
            expect_word(`TLK_SOF, 2'b11, "test start of frame");
            for (int n = 0; n < 256; n++) begin
                n8 = 8'(n);
                expect_word({n8, n8}, 2'b00, "test count word");
            end
        end
    endtask

    task automatic test_reset_mid_frame();
        int irq_base;
        bit quiet;
        bit in_data;
        apply_reset();
        exp_q.delete();
        i_tx_packet_body = 16'd16;
        i_tx_packet_tail = 16'd16;
        i_tx_body_num    = 24'd0;
        irq_base         = irq_count;
        pulse_start(tlk2711_tx_pkg::NORM);
        load_words(2);
        in_data = 1'b0;
        for (int i = 0; i < 100 && !in_data; i++) begin
            @(negedge clk);
            in_data = (status_state() == tlk2711_tx_pkg::DATA);
        end
        if (!in_data) begin
            errors++;
            $display("sequencer never reached the data words of the frame");
        end
        apply_reset();
        check_word("txd after mid-frame reset", o_2711_txd, {o_2711_tkmsb, o_2711_tklsb},
                   16'h0, 2'b00);
        check_state("state after mid-frame reset", status_state(), tlk2711_tx_pkg::IDLE);
        check_bit("interrupt after mid-frame reset", o_tx_interrupt, 1'b0);
        quiet = 1'b1;
        repeat (300) begin
            @(negedge clk);
            if (o_2711_txd !== 16'h0 || o_2711_tkmsb || o_2711_tklsb || o_tx_interrupt) begin
                quiet = 1'b0;
            end
        end
        check_bit("port idle after mid-frame reset", quiet, 1'b1);
        check_bit("no interrupt after mid-frame reset", irq_count == irq_base, 1'b1);
    endtask

    initial begin
        seed             = 32'hd6c6;
        i_soft_reset     = 1'b1;
        i_tx_mode        = tlk2711_tx_pkg::NORM;
        i_loopback_ena   = 1'b1;
        i_tx_pre         = 1'b0;
        i_tx_start       = 1'b0;
        i_tx_packet_body = 16'd0;
        i_tx_packet_tail = 16'd0;
        i_tx_body_num    = 24'd0;
        i_dma_rd_valid   = 1'b0;
        i_dma_rd_data    = 64'h0;

        test_after_reset();
        run_frames(0, 16, 16);
        run_frames(2, 8, 4);
        test_kcode();
        test_pattern();
        test_reset_mid_frame();

        $display("tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/tlk2711_tx_top.sv ====
//////////////////////////////////////////////////////////////////////
// TLK2711 transmit framer, normal / K-code / test modes
// mode is latched on i_tx_start; normal mode needs data preloaded
// chip port words lag their source by one cycle
//////////////////////////////////////////////////////////////////////
`include "tlk2711_tx_macros.svh"

module tlk2711_tx_top (
    input  logic        clk,
    input  logic        i_soft_reset,
    input  logic [2:0]  i_tx_mode,
    input  logic        i_loopback_ena,
    input  logic        i_tx_pre,
    input  logic        i_tx_start,
    input  logic [15:0] i_tx_packet_body,
    input  logic [15:0] i_tx_packet_tail,
    input  logic [23:0] i_tx_body_num,
    input  logic        i_dma_rd_valid,
    input  logic [63:0] i_dma_rd_data,
    output logic        o_dma_rd_ready,
    output logic        o_tx_interrupt,
    output logic [8:0]  o_tx_status,
    output logic        o_2711_tkmsb,
    output logic        o_2711_tklsb,
    output logic        o_2711_enable,
    output logic        o_2711_loopen,
    output logic        o_2711_lckrefn,
    output logic        o_2711_testen,
    output logic        o_2711_prbsen,
    output logic        o_2711_pre,
    output logic [15:0] o_2711_txd
);

    tlk2711_tx_pkg::tx_mode_e  mode_q;
    tlk2711_tx_pkg::tx_state_e seq_state;

    logic        start_norm;
    logic        feed_en;
    logic        run_q;
    logic        chip_on;
    logic        fifo_wr;
    logic        fifo_pop;
    logic        fifo_full;
    logic        fifo_empty;
    logic [15:0] fifo_rdata;
    logic        run_done;
    logic [15:0] seq_txd;
    logic        seq_tkmsb;
    logic        seq_tklsb;
    logic [15:0] pat_txd;
    logic        pat_tkmsb;
    logic        pat_tklsb;

    assign start_norm     = i_tx_start && (i_tx_mode == tlk2711_tx_pkg::NORM);
    assign o_dma_rd_ready = ~fifo_full;
    assign fifo_wr        = i_dma_rd_valid && o_dma_rd_ready && feed_en;
    assign o_tx_status    = {fifo_empty, fifo_full, seq_state, mode_q};

    // static chip controls
    assign o_2711_enable  = chip_on;
    assign o_2711_lckrefn = chip_on;
    assign o_2711_testen  = 1'b0;
    assign o_2711_prbsen  = 1'b0;
    assign o_2711_loopen  = i_loopback_ena;
    assign o_2711_pre     = i_tx_pre;

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            mode_q  <= tlk2711_tx_pkg::NORM;
            feed_en <= 1'b0;
            run_q   <= 1'b0;
            chip_on <= 1'b0;
        end else begin
            chip_on <= 1'b1;
            if (i_tx_start) begin
                mode_q <= tlk2711_tx_pkg::tx_mode_e'(i_tx_mode);
            end
            if (start_norm) begin
                feed_en <= 1'b1;
                run_q   <= 1'b1;
            end else if (run_done) begin
                run_q <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // word sources
    //////////////////////////////////////////////////////////////////////
    tx_word_fifo u_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_wr_en      (fifo_wr),
        .i_wdata      (i_dma_rd_data),
        .i_rd_en      (fifo_pop),
        .o_rdata      (fifo_rdata),
        .o_full       (fifo_full),
        .o_empty      (fifo_empty)
    );

    frame_sequencer u_seq (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_run          (run_q),
        .i_fifo_empty   (fifo_empty),
        .i_fifo_rdata   (fifo_rdata),
        .i_packet_body  (i_tx_packet_body),
        .i_packet_tail  (i_tx_packet_tail),
        .i_body_num     (i_tx_body_num),
        .o_fifo_pop     (fifo_pop),
        .o_txd          (seq_txd),
        .o_tkmsb        (seq_tkmsb),
        .o_tklsb        (seq_tklsb),
        .o_state        (seq_state),
        .o_run_done     (run_done),
        .o_tx_interrupt (o_tx_interrupt)
    );

    test_pattern_gen u_pat (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_enable     (mode_q == tlk2711_tx_pkg::TEST),
        .o_txd        (pat_txd),
        .o_tkmsb      (pat_tkmsb),
        .o_tklsb      (pat_tklsb)
    );

    // chip port register
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_2711_txd   <= 16'h0000;
            o_2711_tkmsb <= 1'b0;
            o_2711_tklsb <= 1'b0;
        end else begin
            case (mode_q)
                tlk2711_tx_pkg::KCODE: begin
                    o_2711_txd   <= `TLK_SOF;
                    o_2711_tkmsb <= 1'b1;
                    o_2711_tklsb <= 1'b1;
                end
                tlk2711_tx_pkg::TEST: begin
                    o_2711_txd   <= pat_txd;
                    o_2711_tkmsb <= pat_tkmsb;
                    o_2711_tklsb <= pat_tklsb;
                end
                default: begin
                    o_2711_txd   <= seq_txd;
                    o_2711_tkmsb <= seq_tkmsb;
                    o_2711_tklsb <= seq_tklsb;
                end
            endcase
        end
    end

endmodule

// ==== hdl/test_pattern_gen.sv ====
//////////////////////////////////////////////////////////////////////
// test mode source: comma, comma, SOF, then {n,n} for n = 0..255
// restarts from the first comma whenever enable drops
//////////////////////////////////////////////////////////////////////
`include "tlk2711_tx_macros.svh"

module test_pattern_gen (
    input  logic        clk,
    input  logic        i_soft_reset,
    input  logic        i_enable,
    output logic [15:0] o_txd,
    output logic        o_tkmsb,
    output logic        o_tklsb
);

    tlk2711_tx_pkg::test_state_e state;
    logic [7:0] cnt;

    always_ff @(posedge clk) begin
        if (i_soft_reset || !i_enable) begin
            state   <= tlk2711_tx_pkg::COMMA1;
            cnt     <= 8'd0;
            o_txd   <= 16'h0000;
            o_tkmsb <= 1'b0;
            o_tklsb <= 1'b0;
        end else begin
            case (state)
                tlk2711_tx_pkg::COMMA1, tlk2711_tx_pkg::COMMA2: begin
                    o_txd              <= `TLK_COMMA;
                    {o_tkmsb, o_tklsb} <= 2'b01;
                    cnt                <= 8'd0;
                    state <= (state == tlk2711_tx_pkg::COMMA1) ? tlk2711_tx_pkg::COMMA2
                                                               : tlk2711_tx_pkg::TSOF;
                end
                tlk2711_tx_pkg::TSOF: begin
                    o_txd              <= `TLK_SOF;
                    {o_tkmsb, o_tklsb} <= 2'b11;
                    state              <= tlk2711_tx_pkg::COUNT;
                end
                default: begin
                    // counting words carry no K flags
                    o_txd              <= {cnt, cnt};
                    {o_tkmsb, o_tklsb} <= 2'b00;
                    cnt                <= cnt + 8'd1;
                    if (&cnt) begin
                        state <= tlk2711_tx_pkg::COMMA1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/frame_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// normal mode framer: sync, frames of length/2 data words, gap, irq
// no stall on FIFO underflow, data for a frame must be loaded first
// lengths are in bytes and should be even and at least 2
//////////////////////////////////////////////////////////////////////
`include "tlk2711_tx_macros.svh"

module frame_sequencer (
    input  logic                      clk,
    input  logic                      i_soft_reset,
    input  logic                      i_run,
    input  logic                      i_fifo_empty,
    input  logic [15:0]               i_fifo_rdata,
    input  logic [15:0]               i_packet_body,
    input  logic [15:0]               i_packet_tail,
    input  logic [23:0]               i_body_num,
    output logic                      o_fifo_pop,
    output logic [15:0]               o_txd,
    output logic                      o_tkmsb,
    output logic                      o_tklsb,
    output tlk2711_tx_pkg::tx_state_e o_state,
    output logic                      o_run_done,
    output logic                      o_tx_interrupt
);

    tlk2711_tx_pkg::tx_state_e state;
    tlk2711_tx_pkg::tx_state_e next_state;

    // shared step counter, cleared on every state change
    logic [15:0] cnt;
    logic [23:0] frame_cnt;
    logic [15:0] len_q;
    logic [15:0] csum;
    logic [15:0] word;
    logic [1:0]  kflags;
    logic        last;
    logic        gap_end;
    logic        done_q;

    assign last    = (frame_cnt == i_body_num);
    assign gap_end = (state == tlk2711_tx_pkg::GAP) && (cnt == 16'(`TLK_GAP_WORDS - 1));

    assign o_state        = state;
    assign o_fifo_pop     = (state == tlk2711_tx_pkg::DATA);
    assign o_run_done     = done_q;
    assign o_tx_interrupt = done_q;

    //////////////////////////////////////////////////////////////////////
    // word of the current state
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        word   = 16'h0000;
        kflags = 2'b00;
        case (state)
            tlk2711_tx_pkg::SYNC, tlk2711_tx_pkg::GAP: begin
                word   = `TLK_COMMA;
                kflags = 2'b01;
            end
            tlk2711_tx_pkg::SOF: begin
                word   = `TLK_SOF;
                kflags = 2'b11;
            end
            tlk2711_tx_pkg::HEAD:      word = cnt[0] ? `TLK_HEAD1 : `TLK_HEAD0;
            tlk2711_tx_pkg::FILE_SIGN: word = {`TLK_TX_IND, last ? `TLK_FILE_END : 8'h00};
            tlk2711_tx_pkg::FRAME_NUM: word = frame_cnt[15:0];
            tlk2711_tx_pkg::LENGTH:    word = len_q;
            tlk2711_tx_pkg::DATA:      word = i_fifo_rdata;
            tlk2711_tx_pkg::CSUM:      word = csum;
            tlk2711_tx_pkg::EOF: begin
                word   = `TLK_EOF;
                kflags = 2'b11;
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            tlk2711_tx_pkg::IDLE: begin
                // done_q blocks a restart while the run flag is still clearing
                if (i_run && !i_fifo_empty && !done_q) begin
                    next_state = tlk2711_tx_pkg::SYNC;
                end
            end
            tlk2711_tx_pkg::SYNC: begin
                if (cnt == 16'(`TLK_SYNC_WORDS - 1)) begin
                    next_state = tlk2711_tx_pkg::SOF;
                end
            end
            tlk2711_tx_pkg::SOF: next_state = tlk2711_tx_pkg::HEAD;
            tlk2711_tx_pkg::HEAD: begin
                if (cnt[0]) begin
                    next_state = tlk2711_tx_pkg::FILE_SIGN;
                end
            end
            tlk2711_tx_pkg::FILE_SIGN: next_state = tlk2711_tx_pkg::FRAME_NUM;
            tlk2711_tx_pkg::FRAME_NUM: next_state = tlk2711_tx_pkg::LENGTH;
            tlk2711_tx_pkg::LENGTH: begin
                next_state = (len_q[15:1] == 15'd0) ? tlk2711_tx_pkg::CSUM
                                                    : tlk2711_tx_pkg::DATA;
            end
            tlk2711_tx_pkg::DATA: begin
                if (cnt == {1'b0, len_q[15:1]} - 16'd1) begin
                    next_state = tlk2711_tx_pkg::CSUM;
                end
            end
            tlk2711_tx_pkg::CSUM: next_state = tlk2711_tx_pkg::EOF;
            tlk2711_tx_pkg::EOF:  next_state = tlk2711_tx_pkg::GAP;
            tlk2711_tx_pkg::GAP: begin
                if (gap_end) begin
                    next_state = last ? tlk2711_tx_pkg::IDLE : tlk2711_tx_pkg::SOF;
                end
            end
            default: next_state = tlk2711_tx_pkg::IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state, counters and output word
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state     <= tlk2711_tx_pkg::IDLE;
            cnt       <= 16'd0;
            frame_cnt <= 24'd0;
            done_q    <= 1'b0;
            o_txd     <= 16'h0000;
            o_tkmsb   <= 1'b0;
            o_tklsb   <= 1'b0;
        end else begin
            state <= next_state;
            cnt   <= (next_state != state) ? 16'd0 : cnt + 16'd1;
            if (state == tlk2711_tx_pkg::IDLE) begin
                frame_cnt <= 24'd0;
            end else if (gap_end && !last) begin
                frame_cnt <= frame_cnt + 24'd1;
            end
            done_q             <= gap_end && last;
            o_txd              <= word;
            {o_tkmsb, o_tklsb} <= kflags;
        end
    end

    // frame length and checksum
    always_ff @(posedge clk) begin
        if (state == tlk2711_tx_pkg::SOF) begin
            len_q <= last ? i_packet_tail : i_packet_body;
            csum  <= 16'h0000;
        end else if (state inside {tlk2711_tx_pkg::FILE_SIGN, tlk2711_tx_pkg::FRAME_NUM,
                                   tlk2711_tx_pkg::LENGTH, tlk2711_tx_pkg::DATA}) begin
            csum <= csum + word;
        end
    end

    // FIFO must hold the whole frame before DATA starts
    a_data_not_empty: assert property (@(posedge clk) disable iff (i_soft_reset)
        state == tlk2711_tx_pkg::DATA |-> !i_fifo_empty);

    // one interrupt per run, the run flag drops right after it
    a_irq_pulse: assert property (@(posedge clk) disable iff (i_soft_reset)
        o_tx_interrupt |=> !o_tx_interrupt && !i_run);

endmodule

// ==== hdl/tx_word_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// first-word-fall-through FIFO, 64-bit writes, 16-bit reads
// half-words leave lowest first; o_empty means no whole entry left
// caller must not write when full or pop when empty
//////////////////////////////////////////////////////////////////////
`include "tlk2711_tx_macros.svh"

module tx_word_fifo (
    input  logic        clk,
    input  logic        i_soft_reset,
    input  logic        i_wr_en,
    input  logic [63:0] i_wdata,
    input  logic        i_rd_en,
    output logic [15:0] o_rdata,
    output logic        o_full,
    output logic        o_empty
);

    localparam int AW = $clog2(`TLK_FIFO_DEPTH);

    logic [63:0]   mem [`TLK_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [1:0]    half;
    logic          entry_done;

    // last half-word of the head entry is being popped
    assign entry_done = i_rd_en && (half == 2'd3);

    assign o_empty = (count == '0);
    assign o_full  = (count == (AW+1)'(`TLK_FIFO_DEPTH));
    assign o_rdata = mem[rd_ptr][{half, 4'b0000} +: 16];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            half   <= 2'd0;
        end else begin
            if (i_wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_rd_en) begin
                half <= half + 2'd1;
            end
            if (entry_done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_wr_en, entry_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // protocol checks on both sides
    //////////////////////////////////////////////////////////////////////

    // DMA side must see ready low while full
    a_no_overflow: assert property (@(posedge clk) disable iff (i_soft_reset)
        i_wr_en |-> !o_full);

    // sequencer only pops preloaded data
    a_no_underflow: assert property (@(posedge clk) disable iff (i_soft_reset)
        i_rd_en |-> !o_empty);

endmodule

// ==== hdl/tlk2711_tx_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// enum types shared by the TLK2711 transmit framer and its testbench
// encodings of tx_state_e show up on the status port
//////////////////////////////////////////////////////////////////////
package tlk2711_tx_pkg;

    // values of i_tx_mode
    typedef enum logic [2:0] {
        NORM  = 3'd0,
        KCODE = 3'd1,
        TEST  = 3'd2
    } tx_mode_e;

    // normal mode frame sequence
    typedef enum logic [3:0] {
        IDLE,
        SYNC,
        SOF,
        HEAD,
        FILE_SIGN,
        FRAME_NUM,
        LENGTH,
        DATA,
        CSUM,
        EOF,
        GAP
    } tx_state_e;

    // test mode pattern
    typedef enum logic [1:0] {
        COMMA1,
        COMMA2,
        TSOF,
        COUNT
    } test_state_e;

endpackage

// ==== include/tlk2711_tx_macros.svh ====
//////////////////////////////////////////////////////////////////////
// code words and fixed lengths for the TLK2711 transmit framer
// code words are {msb byte, lsb byte} as driven on the txd pins
// TLK_FIFO_DEPTH must be a power of two
//////////////////////////////////////////////////////////////////////
`ifndef TLK2711_TX_MACROS_SVH
`define TLK2711_TX_MACROS_SVH

// comma {D5.6, K28.5}, lsb byte is the K character
`define TLK_COMMA       16'hC5BC
// start of frame {K28.2, K27.7}
`define TLK_SOF         16'h5CFB
// end of frame {K29.7, K30.7}
`define TLK_EOF         16'hFDFE

`define TLK_HEAD0       16'hEB90
`define TLK_HEAD1       16'hE116

// file sign bytes
`define TLK_TX_IND      8'h81
`define TLK_FILE_END    8'h01

// comma runs around the frames
`define TLK_SYNC_WORDS  6
`define TLK_GAP_WORDS   256

// 64-bit entries
`define TLK_FIFO_DEPTH  64

`endif
